/* broadcast_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module broadcast_controller
	import md_bcast_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire iter_start,
	input wire [NUM_CELLS*PARTICLE_ID_WIDTH-1:0] particle_num,
	input wire [NUM_CELLS-1:0] back_pressure,
	input wire [NUM_CELLS-1:0] reading_done,
	input wire [NUM_CELLS-1:0] filter_buffer_empty,
	input wire [NUM_CELLS-1:0] credits_full,
	output logic [PARTICLE_ID_WIDTH-1:0] particle_id,
	output logic [PARTICLE_ID_WIDTH-1:0] ref_id,
	output logic phase,
	output logic reading_particle_num,
	output logic pause_reading,
	output logic iter_done
);

	logic [1:0] state;
	logic [WAIT_CNT_WIDTH-1:0] wait_cnt;
	logic [NUM_CELLS-1:0] broadcast_done;
	logic all_broadcast_done;
	logic all_reading_done;
	logic all_buffers_empty;
	logic all_credits_full;
	logic any_back_pressure;

	// per-cell sweep end, one compare against the larger of own and neighbor count
	for (genvar i = 0; i < NUM_CELLS; i++)
	begin : g_done
		logic [PARTICLE_ID_WIDTH-1:0] own_num;
		logic [PARTICLE_ID_WIDTH-1:0] nbr_num;
		logic [PARTICLE_ID_WIDTH-1:0] last_id;

		assign own_num = particle_num[i*PARTICLE_ID_WIDTH +: PARTICLE_ID_WIDTH];
		// ring neighbor, last cell wraps to cell 0
		assign nbr_num = particle_num[((i+1)%NUM_CELLS)*PARTICLE_ID_WIDTH +: PARTICLE_ID_WIDTH];
		assign last_id = (own_num > nbr_num) ? own_num : nbr_num;
		assign broadcast_done[i] = (particle_id >= last_id);
	end

	// reductions over all cells
	assign all_broadcast_done = &broadcast_done;
	assign all_reading_done = &reading_done;
	assign all_buffers_empty = &filter_buffer_empty;
	assign all_credits_full = &credits_full;
	assign any_back_pressure = |back_pressure;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= WAIT_FOR_START;
			wait_cnt <= '0;
			ref_id <= PARTICLE_ID_WIDTH'(1);
			particle_id <= '0;
			phase <= 1'b0;
			reading_particle_num <= 1'b0;
			pause_reading <= 1'b1;
			iter_done <= 1'b0;
		end
		else
		begin
			// single-cycle pulses
			reading_particle_num <= 1'b0;
			iter_done <= 1'b0;
			case (state)
				WAIT_FOR_START:
				begin
					ref_id <= PARTICLE_ID_WIDTH'(1);
					particle_id <= '0;
					phase <= 1'b0;
					// countdown gives the host time to settle the new counts
					if (wait_cnt == WAIT_CNT_WIDTH'(WAIT_CYCLES))
					begin
						state <= READ_PARTICLE_NUM;
						wait_cnt <= '0;
						reading_particle_num <= 1'b1;
						pause_reading <= 1'b0;
					end
					else if (iter_start || wait_cnt != '0)
					begin
						wait_cnt <= wait_cnt + 1'b1;
						pause_reading <= 1'b1;
					end
					else
					begin
						pause_reading <= 1'b1;
					end
				end
				READ_PARTICLE_NUM:
				begin
					// cells latch counts this cycle, sweep starts at id 1
					state <= READING;
					ref_id <= PARTICLE_ID_WIDTH'(1);
					particle_id <= PARTICLE_ID_WIDTH'(1);
					pause_reading <= 1'b0;
				end
				READING:
				begin
					// current id already taken by the cells, hold it while stalled
					if (any_back_pressure)
					begin
						pause_reading <= 1'b1;
					end
					else if (all_broadcast_done)
					begin
						particle_id <= PARTICLE_ID_WIDTH'(1);
						phase <= ~phase;
						if (phase == 1'b0)
						begin
							// same ref, now against the neighbor cell
							pause_reading <= 1'b0;
						end
						else
						begin
							// both phases done for this ref
							state <= WAIT_NEXT_REF;
							ref_id <= ref_id + 1'b1;
							pause_reading <= 1'b1;
						end
					end
					else
					begin
						particle_id <= particle_id + 1'b1;
						pause_reading <= 1'b0;
					end
				end
				WAIT_NEXT_REF:
				begin
					// drain every buffer before the next ref or the end
					if (!all_buffers_empty)
					begin
						pause_reading <= 1'b1;
					end
					else if (all_reading_done)
					begin
						pause_reading <= 1'b1;
						// iteration ends only once every credit is back
						if (all_credits_full)
						begin
							state <= WAIT_FOR_START;
							iter_done <= 1'b1;
							ref_id <= PARTICLE_ID_WIDTH'(1);
							particle_id <= '0;
							phase <= 1'b0;
						end
					end
					else
					begin
						state <= READING;
						pause_reading <= 1'b0;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* cell_pair_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module cell_pair_filter
	import md_bcast_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire [PARTICLE_ID_WIDTH-1:0] particle_num_in,
	input wire [PARTICLE_ID_WIDTH-1:0] neighbor_num_in,
	input wire [PARTICLE_ID_WIDTH-1:0] particle_id,
	input wire [PARTICLE_ID_WIDTH-1:0] ref_id,
	input wire phase,
	input wire reading_particle_num,
	input wire pause_reading,
	input wire credit_return,
	output logic back_pressure,
	output logic reading_done,
	output logic filter_buffer_empty,
	output logic credits_full,
	output logic pair_valid,
	output logic [PARTICLE_ID_WIDTH-1:0] pair_ref,
	output logic [PARTICLE_ID_WIDTH-1:0] pair_partner,
	output logic pair_phase
);

	logic [PARTICLE_ID_WIDTH-1:0] own_num;
	logic [PARTICLE_ID_WIDTH-1:0] nbr_num;
	logic bcast_valid;
	logic ref_in_cell;
	logic partner_ok;
	logic accept;
	logic stage_valid;
	logic [PARTICLE_ID_WIDTH-1:0] stage_ref;
	logic [PARTICLE_ID_WIDTH-1:0] stage_partner;
	logic stage_phase;
	logic fifo_push;
	logic fifo_pop;
	logic fifo_empty;
	logic [FIFO_LEVEL_WIDTH-1:0] fifo_level;
	logic [PAIR_WIDTH-1:0] fifo_head;
	logic [CREDIT_WIDTH-1:0] credits;

	// counts held for the whole iteration
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			own_num <= '0;
			nbr_num <= '0;
		end
		else if (reading_particle_num)
		begin
			own_num <= particle_num_in;
			nbr_num <= neighbor_num_in;
		end
	end

	// count pulse cycle carries no pair
	assign bcast_valid = !pause_reading && !reading_particle_num;
	assign ref_in_cell = (ref_id <= own_num);
	// phase 0 higher ids of own cell, phase 1 every id of the neighbor
	assign partner_ok = phase ? (particle_id != '0 && particle_id <= nbr_num)
		: (ref_id < particle_id && particle_id <= own_num);
	assign accept = bcast_valid && ref_in_cell && partner_ok;

	// one registered acceptance stage
	always_ff @(posedge clk)
	begin
		if (rst)
			stage_valid <= 1'b0;
		else
			stage_valid <= accept;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			stage_ref <= ref_id;
			stage_partner <= particle_id;
			stage_phase <= phase;
		end
	end

	assign fifo_push = stage_valid;

	pair_fifo fifo_i (
		.clk(clk),
		.rst(rst),
		.push(fifo_push),
		.push_data({stage_ref, stage_partner, stage_phase}),
		.pop(fifo_pop),
		.pop_data(fifo_head),
		.empty(fifo_empty),
		.level(fifo_level)
	);

	// send the head whenever a credit is left
	assign pair_valid = !fifo_empty && (credits != '0);
	assign fifo_pop = pair_valid;
	assign {pair_ref, pair_partner, pair_phase} = fifo_head;

	// one credit per sent pair, one back per return pulse
	always_ff @(posedge clk)
	begin
		if (rst)
			credits <= CREDIT_WIDTH'(FORCE_CREDITS);
		else
		begin
			case ({fifo_pop, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	assign credits_full = (credits == CREDIT_WIDTH'(FORCE_CREDITS));
	assign back_pressure = (fifo_level >= FIFO_LEVEL_WIDTH'(BP_LEVEL));
	// stage register counts as buffered too
	assign filter_buffer_empty = fifo_empty && !stage_valid;
	assign reading_done = (ref_id > own_num);

endmodule

`default_nettype wire

/* md_bcast_pkg.sv */
`default_nettype none

package md_bcast_pkg;

	// ring size, any value of 2 or more
	localparam int NUM_CELLS = 4;

	// particle ids start at 1, a count of 0 means an empty cell
	localparam int PARTICLE_ID_WIDTH = 7;

	// filter buffer
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
	localparam int FIFO_LEVEL_WIDTH = $clog2(FIFO_DEPTH + 1);
	// back-pressure leaves room for the two pairs still in flight
	localparam int BP_LEVEL = 5;

	// {ref, partner, phase}
	localparam int PAIR_WIDTH = 2 * PARTICLE_ID_WIDTH + 1;

	// credits each cell holds towards the force unit
	localparam int FORCE_CREDITS = 4;
	localparam int CREDIT_WIDTH = $clog2(FORCE_CREDITS + 1);

	// idle cycles between iter_start and the count pulse
	localparam int WAIT_CYCLES = 10;
	localparam int WAIT_CNT_WIDTH = $clog2(WAIT_CYCLES + 1);

	// controller states
	localparam logic [1:0] WAIT_FOR_START = 2'b00;
	localparam logic [1:0] READ_PARTICLE_NUM = 2'b01;
	localparam logic [1:0] READING = 2'b10;
	localparam logic [1:0] WAIT_NEXT_REF = 2'b11;

endpackage

`default_nettype wire

/* pair_broadcast_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module pair_broadcast_assert
	import md_bcast_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire pair_valid,
	input wire credit_return,
	input wire [CREDIT_WIDTH-1:0] credits,
	input wire push,
	input wire [FIFO_LEVEL_WIDTH-1:0] level
);

	// pairs out at the force unit as seen on the cell ports
	logic [CREDIT_WIDTH-1:0] outstanding;

	always_ff @(posedge clk)
	begin
		if (rst)
			outstanding <= '0;
		else
			outstanding <= outstanding + CREDIT_WIDTH'(pair_valid)
				- CREDIT_WIDTH'(credit_return);
	end

	// a pair leaves only against a held credit
	a_valid_has_credit: assert property (@(posedge clk) disable iff (rst)
		pair_valid |-> outstanding < CREDIT_WIDTH'(FORCE_CREDITS))
		else $error("pair_valid with no credit left");

	// back-pressure must leave room for pairs in flight
	a_no_push_full: assert property (@(posedge clk) disable iff (rst)
		push |-> level != FIFO_LEVEL_WIDTH'(FIFO_DEPTH))
		else $error("push into a full filter buffer");

	// more returns than sends
	a_credit_limit: assert property (@(posedge clk) disable iff (rst)
		credits <= CREDIT_WIDTH'(FORCE_CREDITS))
		else $error("credit counter above its limit");

endmodule

bind cell_pair_filter pair_broadcast_assert assert_i (
	.clk(clk),
	.rst(rst),
	.pair_valid(pair_valid),
	.credit_return(credit_return),
	.credits(credits),
	.push(fifo_push),
	.level(fifo_level)
);

`default_nettype wire

/* pair_broadcast_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pair_broadcast_tb
	import md_bcast_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int NUM_ROWS = 6;
	localparam int DONE_TIMEOUT = 100000;
	localparam int DRAIN_CYCLES = 6;
	// table counts stay at 12 or below
	localparam int MAP_SIZE = 16;

	logic clk;
	logic rst;
	logic iter_start;
	logic [NUM_CELLS*PARTICLE_ID_WIDTH-1:0] particle_num;
	logic [NUM_CELLS-1:0] credit_return;
	wire [NUM_CELLS-1:0] pair_valid;
	wire [NUM_CELLS*PARTICLE_ID_WIDTH-1:0] pair_ref;
	wire [NUM_CELLS*PARTICLE_ID_WIDTH-1:0] pair_partner;
	wire [NUM_CELLS-1:0] pair_phase;
	wire iter_done;

	// four cell counts, then the credit delay limit
	int row_tab [NUM_ROWS][NUM_CELLS+1];
	int cur_num [NUM_CELLS];
	int limit;
	// force unit side, credits held and time to the next return
	int owed [NUM_CELLS];
	int timer [NUM_CELLS];
	// received pairs per cell and phase
	bit seen [NUM_CELLS][2][MAP_SIZE][MAP_SIZE];
	int pair_cnt [NUM_CELLS][2];
	integer seed;
	int errors;
	int tests;
	int failed;
	int errors_before;
	bit running;
	bit timed_out;

	pair_broadcast_top dut_i (
		.clk(clk),
		.rst(rst),
		.iter_start(iter_start),
		.particle_num(particle_num),
		.credit_return(credit_return),
		.pair_valid(pair_valid),
		.pair_ref(pair_ref),
		.pair_partner(pair_partner),
		.pair_phase(pair_phase),
		.iter_done(iter_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// random wait before a credit goes back, 0 up to the row limit
	function automatic int credit_delay();
		return int'($unsigned($random(seed)) % (limit + 1));
	endfunction

	task automatic record_pair(input int c);
		int r;
		int p;
		int ph;
		int nbr;
		bit ok;
		r = int'(pair_ref[c*PARTICLE_ID_WIDTH +: PARTICLE_ID_WIDTH]);
		p = int'(pair_partner[c*PARTICLE_ID_WIDTH +: PARTICLE_ID_WIDTH]);
		ph = int'(pair_phase[c]);
		nbr = cur_num[(c + 1) % NUM_CELLS];
		if (!running)
		begin
			errors++;
			$display("error: pair_valid[%0d] is %h outside an iteration", c, pair_valid[c]);
		end
		// a credit driven back now is not yet counted by the cell
		if (owed[c] + int'(credit_return[c]) >= FORCE_CREDITS)
		begin
			errors++;
			$display("error: pair_valid[%0d] is %h with credits held %h", c, pair_valid[c],
				owed[c] + int'(credit_return[c]));
		end
		// phase 0 higher ids of own cell, phase 1 any id of the neighbor
		if (ph == 0)
			ok = (r >= 1 && r < p && p <= cur_num[c]);
		else
			ok = (r >= 1 && r <= cur_num[c] && p >= 1 && p <= nbr);
		if (!ok)
		begin
			errors++;
			$display("error: cell %0d pair_ref %h pair_partner %h pair_phase %h outside counts %h %h",
				c, r, p, ph, cur_num[c], nbr);
		end
		else if (seen[c][ph][r][p])
		begin
			errors++;
			$display("cell %0d sent ref %0d partner %0d phase %0d twice", c, r, p, ph);
		end
		else
		begin
			seen[c][ph][r][p] = 1'b1;
			pair_cnt[c][ph]++;
		end
		owed[c]++;
	endtask

	task automatic return_credits();
		for (int c = 0; c < NUM_CELLS; c++)
		begin
			credit_return[c] = 1'b0;
			if (owed[c] > 0)
			begin
				if (timer[c] == 0)
				begin
					credit_return[c] = 1'b1;
					owed[c]--;
					timer[c] = credit_delay();
				end
				else
					timer[c]--;
			end
		end
	endtask

	// one clock: sample at the falling edge, drive just after the rising edge
	task automatic step();
		@(negedge clk);
		for (int c = 0; c < NUM_CELLS; c++)
		begin
			if (pair_valid[c])
				record_pair(c);
		end
		if (iter_done)
		begin
			if (!running)
			begin
				errors++;
				$display("error: iter_done is %h outside an iteration", iter_done);
			end
			running = 1'b0;
		end
		@(posedge clk);
		#2;
		return_credits();
	endtask

	task automatic clear_maps();
		for (int c = 0; c < NUM_CELLS; c++)
		begin
			pair_cnt[c][0] = 0;
			pair_cnt[c][1] = 0;
			for (int ph = 0; ph < 2; ph++)
				for (int r = 0; r < MAP_SIZE; r++)
					for (int p = 0; p < MAP_SIZE; p++)
						seen[c][ph][r][p] = 1'b0;
		end
	endtask

	// n(n-1)/2 inside the cell, n_i*n_(i+1) towards the neighbor
	task automatic check_counts();
		int n;
		int nbr;
		int exp_cnt [2];
		for (int c = 0; c < NUM_CELLS; c++)
		begin
			n = cur_num[c];
			nbr = cur_num[(c + 1) % NUM_CELLS];
			exp_cnt[0] = n * (n - 1) / 2;
			exp_cnt[1] = n * nbr;
			for (int ph = 0; ph < 2; ph++)
			begin
				if (pair_cnt[c][ph] != exp_cnt[ph])
				begin
					errors++;
					$display("error: cell %0d phase %0d pair_valid count %h expected %h",
						c, ph, pair_cnt[c][ph], exp_cnt[ph]);
				end
			end
		end
	endtask

	task automatic run_row(input int row);
		int cyc;
		errors_before = errors;
		clear_maps();
		limit = row_tab[row][NUM_CELLS];
		for (int c = 0; c < NUM_CELLS; c++)
		begin
			cur_num[c] = row_tab[row][c];
			particle_num[c*PARTICLE_ID_WIDTH +: PARTICLE_ID_WIDTH] =
				PARTICLE_ID_WIDTH'(row_tab[row][c]);
		end
		step();
		iter_start = 1'b1;
		running = 1'b1;
		step();
		iter_start = 1'b0;
		cyc = 0;
		while (running && cyc < DONE_TIMEOUT)
		begin
			step();
			cyc++;
		end
		if (running)
		begin
			errors++;
			timed_out = 1'b1;
			$display("row %0d: no iter_done within %0d cycles", row, DONE_TIMEOUT);
		end
		else
		begin
			// idle window catches late pairs or a second iter_done
			repeat (DRAIN_CYCLES) step();
			check_counts();
		end
		tests++;
		if (errors != errors_before)
			failed++;
		$display("row %0d counts %0d %0d %0d %0d delay %0d: %s", row, cur_num[0], cur_num[1],
			cur_num[2], cur_num[3], limit, (errors == errors_before) ? "ok" : "failed");
	endtask

	initial
	begin
		seed = 32'hbbf4;
		errors = 0;
		tests = 0;
		failed = 0;
		running = 1'b0;
		timed_out = 1'b0;
		limit = 0;
		rst = 1'b1;
		iter_start = 1'b0;
		particle_num = '0;
		credit_return = '0;
		for (int c = 0; c < NUM_CELLS; c++)
		begin
			owed[c] = 0;
			timer[c] = 0;
			cur_num[c] = 0;
		end
		// empty ring, lone particle, mixed, long credit delay for stalls, full
		row_tab = '{
			'{0, 0, 0, 0, 3},
			'{1, 0, 0, 0, 2},
			'{3, 5, 2, 4, 1},
			'{12, 7, 0, 9, 2},
			'{6, 6, 6, 6, 30},
			'{12, 12, 12, 12, 6}
		};
		repeat (4) step();
		rst = 1'b0;

		// idle after reset, step flags any pair_valid or iter_done
		errors_before = errors;
		repeat (8) step();
		tests++;
		if (errors != errors_before)
			failed++;
		$display("reset idle: %s", (errors == errors_before) ? "ok" : "failed");

		for (int row = 0; row < NUM_ROWS && !timed_out; row++)
			run_row(row);

		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* pair_broadcast_top.f */
md_bcast_pkg.sv
pair_fifo.sv
cell_pair_filter.sv
broadcast_controller.sv
pair_broadcast_top.sv
pair_broadcast_assert.sv
pair_broadcast_tb.sv

/* pair_broadcast_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pair_broadcast_top
	import md_bcast_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire iter_start,
	input wire [NUM_CELLS*PARTICLE_ID_WIDTH-1:0] particle_num,
	input wire [NUM_CELLS-1:0] credit_return,
	output wire [NUM_CELLS-1:0] pair_valid,
	output wire [NUM_CELLS*PARTICLE_ID_WIDTH-1:0] pair_ref,
	output wire [NUM_CELLS*PARTICLE_ID_WIDTH-1:0] pair_partner,
	output wire [NUM_CELLS-1:0] pair_phase,
	output wire iter_done
);

	// broadcast bus
	wire [PARTICLE_ID_WIDTH-1:0] particle_id;
	wire [PARTICLE_ID_WIDTH-1:0] ref_id;
	wire phase;
	wire reading_particle_num;
	wire pause_reading;

	// status back from the cells
	wire [NUM_CELLS-1:0] back_pressure;
	wire [NUM_CELLS-1:0] reading_done;
	wire [NUM_CELLS-1:0] filter_buffer_empty;
	wire [NUM_CELLS-1:0] credits_full;

	broadcast_controller ctrl_i (
		.clk(clk),
		.rst(rst),
		.iter_start(iter_start),
		.particle_num(particle_num),
		.back_pressure(back_pressure),
		.reading_done(reading_done),
		.filter_buffer_empty(filter_buffer_empty),
		.credits_full(credits_full),
		.particle_id(particle_id),
		.ref_id(ref_id),
		.phase(phase),
		.reading_particle_num(reading_particle_num),
		.pause_reading(pause_reading),
		.iter_done(iter_done)
	);

	for (genvar i = 0; i < NUM_CELLS; i++)
	begin : g_cell
		// cell i pairs with cell i+1, last one wraps to cell 0
		cell_pair_filter cell_i (
			.clk(clk),
			.rst(rst),
			.particle_num_in(particle_num[i*PARTICLE_ID_WIDTH +: PARTICLE_ID_WIDTH]),
			.neighbor_num_in(particle_num[((i+1)%NUM_CELLS)*PARTICLE_ID_WIDTH +: PARTICLE_ID_WIDTH]),
			.particle_id(particle_id),
			.ref_id(ref_id),
			.phase(phase),
			.reading_particle_num(reading_particle_num),
			.pause_reading(pause_reading),
			.credit_return(credit_return[i]),
			.back_pressure(back_pressure[i]),
			.reading_done(reading_done[i]),
			.filter_buffer_empty(filter_buffer_empty[i]),
			.credits_full(credits_full[i]),
			.pair_valid(pair_valid[i]),
			.pair_ref(pair_ref[i*PARTICLE_ID_WIDTH +: PARTICLE_ID_WIDTH]),
			.pair_partner(pair_partner[i*PARTICLE_ID_WIDTH +: PARTICLE_ID_WIDTH]),
			.pair_phase(pair_phase[i])
		);
	end

endmodule

`default_nettype wire

/* pair_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module pair_fifo
	import md_bcast_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire push,
	input wire [PAIR_WIDTH-1:0] push_data,
	input wire pop,
	output logic [PAIR_WIDTH-1:0] pop_data,
	output logic empty,
	output logic [FIFO_LEVEL_WIDTH-1:0] level
);

	logic [PAIR_WIDTH-1:0] mem [FIFO_DEPTH];
	logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
	logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
	logic wr_en;
	logic rd_en;

	// wrap for any depth, not only powers of two
	function automatic logic [FIFO_PTR_WIDTH-1:0] ptr_inc(
		input logic [FIFO_PTR_WIDTH-1:0] ptr
	);
		if (ptr == FIFO_PTR_WIDTH'(FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign empty = (level == '0);
	// a push into a full buffer is dropped
	assign wr_en = push && (level != FIFO_LEVEL_WIDTH'(FIFO_DEPTH));
	assign rd_en = pop && !empty;
	// head shown without a read cycle
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= ptr_inc(wr_ptr);
			if (rd_en)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({wr_en, rd_en})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the pair broadcast testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_pair_broadcast

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module pair_broadcast_tb \
	--Mdir obj_dir -o "$BIN" \
	-f pair_broadcast_top.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
	echo "simulation log has no result line"
	exit 1
fi
exit 0
